/* Bender.yml */
package:
  name: processorci

sources:
  # Packages first, the RTL depends on them
  - src/processorci_bus_pkg.sv
  - src/processorci_cfg_pkg.sv
  - src/core_reset_ctrl.sv
  - src/ahb_wb_bridge.sv
  - src/wb_addr_decode.sv
  - src/wb_memory.sv
  - src/wb_mtimer.sv
  - src/processorci_top.sv
  - target: simulation
    files:
      - sim/tb_processorci_top.sv

/* processorci.f */
src/processorci_bus_pkg.sv
src/processorci_cfg_pkg.sv
src/core_reset_ctrl.sv
src/ahb_wb_bridge.sv
src/wb_addr_decode.sv
src/wb_memory.sv
src/wb_mtimer.sv
src/processorci_top.sv
sim/tb_processorci_top.sv

/* sim/tb_processorci_top.sv */
`default_nettype none

module tb_processorci_top
	import processorci_bus_pkg::*;
	import processorci_cfg_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          CLK_PERIOD     = 8;
	localparam logic [31:0] LFSR_SEED      = 32'd9;
	localparam int          TIMEOUT_CYCLES = 4000;   // Far above the length of all tests
	localparam int          MAX_OPS        = 64;
	localparam addr_t       UNMAPPED_ADDR  = 32'h4000_0000;

	logic    sys_clk = 1'b0;
	logic    rst;
	addr_t   haddr;
	logic    hwrite;
	htrans_t htrans;
	hsize_t  hsize;
	data_t   hwdata;
	data_t   hrdata;
	logic    hready;
	logic    hresp;
	logic    rst_core;
	logic    timer_irq;

	// Transfer list and what came back for each entry
	addr_t  op_addr [MAX_OPS];
	logic   op_write [MAX_OPS];
	hsize_t op_size [MAX_OPS];
	data_t  op_data [MAX_OPS];
	data_t  res_data [MAX_OPS];
	logic   res_resp [MAX_OPS];
	logic   res_errlow [MAX_OPS];   // hresp seen while hready low
	int     res_cycles [MAX_OPS];   // Data phase length

	data_t      model [MEM_WORDS];
	mem_index_t used [$];   // Words that hold known data
	string      test_name;
	logic [31:0] lfsr;
	int         cycle_cnt = 0;

	processorci_top u_dut (
		.sys_clk_i   (sys_clk),
		.rst_i       (rst),
		.haddr_i     (haddr),
		.hwrite_i    (hwrite),
		.htrans_i    (htrans),
		.hsize_i     (hsize),
		.hwdata_i    (hwdata),
		.hrdata_o    (hrdata),
		.hready_o    (hready),
		.hresp_o     (hresp),
		.rst_core_o  (rst_core),
		.timer_irq_o (timer_irq)
	);

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val  = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
		end
		return val;
	endfunction

	// Lanes of the bytes a transfer covers from its aligned offset
	function automatic strb_t lane_mask(input hsize_t size, input logic [1:0] ofs);
		strb_t mask;
		int    nbytes;
		int    low;
		nbytes = (size == HSIZE_BYTE) ? 1 : ((size == HSIZE_HALF) ? 2 : 4);
		low    = (int'(ofs) / nbytes) * nbytes;
		for (int b = 0; b < 4; b++)
			mask[b] = (b >= low) && (b < low + nbytes);
		return mask;
	endfunction

	function automatic data_t merge_lanes(input data_t old_w, input data_t new_w,
		input strb_t mask);
		data_t res;
		for (int b = 0; b < 4; b++)
			res[8*b +: 8] = mask[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
		return res;
	endfunction

	function automatic bit in_memory(input addr_t a);
		return (a >= MEM_BASE) && (a < MEM_BASE + MEM_SPAN);
	endfunction

	function automatic bit in_timer(input addr_t a);
		return (a >= TIMER_BASE) && (a < TIMER_BASE + 32'h10);
	endfunction

	function automatic hsize_t random_size();
		logic [1:0] sz;
		sz = next_bits(2);
		return (sz == 2'd3) ? HSIZE_WORD : hsize_t'(sz);
	endfunction

	// Aligned address inside a word with known contents
	function automatic addr_t random_addr(input hsize_t size);
		mem_index_t idx;
		logic [1:0] ofs;
		idx = used[next_bits(4) % used.size()];
		ofs = next_bits(2);
		if (size == HSIZE_HALF)
			ofs[0] = 1'b0;
		if (size == HSIZE_WORD)
			ofs = 2'b00;
		return MEM_BASE + addr_t'({idx, ofs});
	endfunction

	task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
		if (act !== exp) begin
			$display("Error in %s, %s: expected %0h, actual %0h", test_name, what, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// Memory model update or read check once a transfer is done
	task automatic finish_op(input int i);
		mem_index_t idx;
		idx = mem_index_t'((op_addr[i] - MEM_BASE) >> 2);
		if (in_memory(op_addr[i]) || in_timer(op_addr[i])) begin
			compare("hresp", 0, res_resp[i]);
			compare("data phase cycles", 2, res_cycles[i]);
		end
		if (in_memory(op_addr[i])) begin
			if (op_write[i])
				model[idx] = merge_lanes(model[idx], op_data[i],
					lane_mask(op_size[i], op_addr[i][1:0]));
			else
				compare($sformatf("read data at %h", op_addr[i]), model[idx], res_data[i]);
		end
	endtask

	// Runs n transfers back to back with each address phase over the previous data phase
	task automatic run_ops(input int n);
		int    nxt;
		int    ap;
		int    dp;
		logic  rdy;
		logic  s_ready;
		logic  s_resp;
		data_t s_data;
		bit    done;
		nxt  = 0;
		ap   = -1;
		dp   = -1;
		rdy  = 1'b1;
		done = 1'b0;
		for (int i = 0; i < n; i++) begin
			res_cycles[i] = 0;
			res_errlow[i] = 1'b0;
		end
		while (!done) begin
			@(negedge sys_clk);
			if (rdy) begin   // Previous cycle moved the pipeline on
				dp = ap;
				ap = (nxt < n) ? nxt : -1;
				if (nxt < n)
					nxt++;
			end
			s_ready = hready;
			s_resp  = hresp;
			s_data  = hrdata;
			if (ap >= 0) begin
				htrans = HTRANS_NONSEQ;
				haddr  = op_addr[ap];
				hwrite = op_write[ap];
				hsize  = op_size[ap];
			end else begin
				htrans = HTRANS_IDLE;
			end
			hwdata = (dp >= 0 && op_write[dp]) ? op_data[dp] : '0;
			if (dp >= 0) begin
				res_cycles[dp]++;
				if (s_resp && !s_ready)
					res_errlow[dp] = 1'b1;
				if (s_ready) begin
					res_data[dp] = s_data;
					res_resp[dp] = s_resp;
					finish_op(dp);
				end
			end
			rdy  = s_ready;
			done = s_ready && ap < 0;
		end
	endtask

	task automatic ahb_write(input addr_t addr, input hsize_t size, input data_t data);
		op_addr[0]  = addr;
		op_write[0] = 1'b1;
		op_size[0]  = size;
		op_data[0]  = data;
		run_ops(1);
	endtask

	task automatic ahb_read(input addr_t addr, input hsize_t size,
		output data_t data, output logic resp);
		op_addr[0]  = addr;
		op_write[0] = 1'b0;
		op_size[0]  = size;
		op_data[0]  = '0;
		run_ops(1);
		data = res_data[0];
		resp = res_resp[0];
	endtask

	task automatic reset_release();
		test_name = "reset_release";
		repeat (3) @(negedge sys_clk);
		compare("core reset during system reset", 1, rst_core);
		rst = 1'b0;
		for (int i = 1; i <= RESET_CLK_CYCLES; i++) begin
			@(negedge sys_clk);
			compare($sformatf("core reset after %0d edges", i), (i < RESET_CLK_CYCLES), rst_core);
		end
		compare("hready after reset", 1, hready);
		compare("hresp after reset", 0, hresp);
		compare("timer irq after reset", 0, timer_irq);
	endtask

	task automatic word_access();
		mem_index_t idx;
		data_t      rdata;
		logic       resp;
		test_name = "word_access";
		for (int i = 0; i < 16; i++) begin
			idx = mem_index_t'(next_bits($bits(mem_index_t)));
			used.push_back(idx);
			ahb_write(MEM_BASE + addr_t'({idx, 2'b00}), HSIZE_WORD, next_bits(32));
		end
		foreach (used[i])
			ahb_read(MEM_BASE + addr_t'({used[i], 2'b00}), HSIZE_WORD, rdata, resp);
	endtask

	task automatic lane_writes();
		hsize_t size;
		addr_t  addr;
		data_t  rdata;
		logic   resp;
		test_name = "lane_writes";
		for (int i = 0; i < 24; i++) begin
			size = random_size();
			addr = random_addr(size);
			ahb_write(addr, size, next_bits(32));
			ahb_read(addr & ~32'h3, HSIZE_WORD, rdata, resp);   // Whole word back
		end
	endtask

	task automatic overlapped_transfers();
		test_name = "overlapped_transfers";
		for (int i = 0; i < MAX_OPS; i++) begin
			op_write[i] = next_bits(1);
			op_size[i]  = random_size();
			op_addr[i]  = random_addr(op_size[i]);
			op_data[i]  = next_bits(32);
		end
		run_ops(MAX_OPS);
	endtask

	task automatic unmapped_access();
		addr_t addr;
		data_t rdata;
		logic  resp;
		test_name = "unmapped_access";
		ahb_read(UNMAPPED_ADDR, HSIZE_WORD, rdata, resp);
		compare("error data phase cycles", 3, res_cycles[0]);
		compare("hresp with hready low", 1, res_errlow[0]);
		compare("hresp with hready high", 1, resp);
		addr = random_addr(HSIZE_WORD);
		ahb_write(addr, HSIZE_WORD, next_bits(32));
		ahb_read(addr, HSIZE_WORD, rdata, resp);
	endtask

	task automatic timer_interrupt();
		data_t t0;
		data_t t1;
		logic  resp;
		int    waited;
		test_name = "timer_interrupt";
		compare("irq before compare set", 0, timer_irq);
		ahb_read(TIMER_BASE + MTIME_LO, HSIZE_WORD, t0, resp);
		ahb_read(TIMER_BASE + MTIME_LO, HSIZE_WORD, t1, resp);
		compare("mtime increasing", 1, t1 > t0);
		ahb_write(TIMER_BASE + MTIMECMP_LO, HSIZE_WORD, t1 + 100);
		ahb_write(TIMER_BASE + MTIMECMP_HI, HSIZE_WORD, 32'h0);
		repeat (2) @(negedge sys_clk);   // Registered irq follows the new compare value
		compare("irq before compare reached", 0, timer_irq);
		waited = 0;
		while (!timer_irq && waited < 200) begin
			@(negedge sys_clk);
			waited++;
		end
		compare("irq within 200 cycles", 1, timer_irq);
		ahb_write(TIMER_BASE + MTIMECMP_HI, HSIZE_WORD, 32'hFFFF_FFFF);
		repeat (2) @(negedge sys_clk);   // Registered irq trails the compare write
		compare("irq cleared", 0, timer_irq);
	endtask

	initial begin
		lfsr   = LFSR_SEED;
		rst    = 1'b1;
		haddr  = '0;
		hwrite = 1'b0;
		htrans = HTRANS_IDLE;
		hsize  = HSIZE_WORD;
		hwdata = '0;
		reset_release();
		word_access();
		lane_writes();
		overlapped_transfers();
		unmapped_access();
		timer_interrupt();
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

/* src/ahb_wb_bridge.sv */
`default_nettype none

module ahb_wb_bridge
	import processorci_bus_pkg::*;
(
	input  logic    sys_clk_i,
	input  logic    rst_i,

	// AHB-Lite subordinate side
	input  addr_t   haddr_i,
	input  logic    hwrite_i,
	input  htrans_t htrans_i,
	input  hsize_t  hsize_i,
	input  data_t   hwdata_i,
	output data_t   hrdata_o,
	output logic    hready_o,
	output logic    hresp_o,

	// Wishbone manager side
	output logic    wb_cyc_o,
	output logic    wb_stb_o,
	output logic    wb_we_o,
	output addr_t   wb_adr_o,
	output strb_t   wb_sel_o,
	output data_t   wb_dat_o,
	input  data_t   wb_dat_i,
	input  logic    wb_ack_i,
	input  logic    wb_err_i
);

	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		ERR_FIRST,
		ERR_SECOND
	} state_t;

	state_t state_q;
	state_t state_d;
	state_t phase;     // State as seen by the AHB outputs this cycle
	addr_t  adr_q;
	logic   we_q;
	strb_t  sel_q;
	strb_t  sel_d;
	logic   accept;

	// Lane select from size and low address bits
	always_comb begin
		case (hsize_i)
			HSIZE_BYTE: sel_d = strb_t'(4'b0001 << haddr_i[1:0]);
			HSIZE_HALF: sel_d = haddr_i[1] ? 4'b1100 : 4'b0011;
			HSIZE_WORD: sel_d = 4'b1111;
			default:    sel_d = 4'b1111;   // Wider sizes not supported
		endcase
	end

	// An err from the decoder opens the error response in the same cycle
	always_comb begin
		phase = state_q;
		if (state_q == ACCESS && wb_err_i)
			phase = ERR_FIRST;
	end

	always_comb begin
		hready_o = 1'b1;
		hresp_o  = 1'b0;
		case (phase)
			ACCESS:     hready_o = wb_ack_i;   // Complete on ack
			ERR_FIRST: begin
				hresp_o  = 1'b1;
				hready_o = 1'b0;
			end
			ERR_SECOND: hresp_o = 1'b1;
			default: ;
		endcase
	end

	// NONSEQ or SEQ with the bus ready
	assign accept = hready_o && ((htrans_i & HTRANS_NONSEQ) != HTRANS_IDLE);

	always_comb begin
		state_d = state_q;
		if (phase == ERR_FIRST)
			state_d = ERR_SECOND;
		else if (accept)
			state_d = ACCESS;   // Next transfer overlaps the completing one
		else if (hready_o)
			state_d = IDLE;
	end

	always_ff @(posedge sys_clk_i) begin
		if (rst_i)
			state_q <= IDLE;
		else
			state_q <= state_d;
	end

	// Address phase capture
	always_ff @(posedge sys_clk_i) begin
		if (accept) begin
			adr_q <= haddr_i;
			we_q  <= hwrite_i;
			sel_q <= sel_d;
		end
	end

	assign wb_cyc_o = (state_q == ACCESS);
	assign wb_stb_o = (state_q == ACCESS);
	assign wb_we_o  = we_q;
	assign wb_adr_o = adr_q;
	assign wb_sel_o = sel_q;
	assign wb_dat_o = hwdata_i;   // Held stable by the manager until hready
	assign hrdata_o = wb_dat_i;

endmodule

`default_nettype wire

/* src/core_reset_ctrl.sv */
`default_nettype none

module core_reset_ctrl
	import processorci_cfg_pkg::*;
(
	input  logic sys_clk_i,
	input  logic rst_i,
	output logic rst_core_o
);

	reset_cnt_t cnt_q;

	// Loaded during system reset, counts down once it is released
	always_ff @(posedge sys_clk_i) begin
		if (rst_i)
			cnt_q <= reset_cnt_t'(RESET_CLK_CYCLES);
		else if (cnt_q != '0)
			cnt_q <= cnt_q - 1'b1;
	end

	// Drops right after the last counted edge
	assign rst_core_o = (cnt_q != '0);

endmodule

`default_nettype wire

/* src/processorci_bus_pkg.sv */
`default_nettype none

package processorci_bus_pkg;

	typedef logic [31:0] addr_t;   // Byte address
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;   // Bit n enables byte n
	typedef logic [1:0]  htrans_t;
	typedef logic [2:0]  hsize_t;

	// SEQ is handled as NONSEQ and BUSY as IDLE
	localparam htrans_t HTRANS_IDLE   = 2'b00;
	localparam htrans_t HTRANS_NONSEQ = 2'b10;

	localparam hsize_t HSIZE_BYTE = 3'd0;
	localparam hsize_t HSIZE_HALF = 3'd1;
	localparam hsize_t HSIZE_WORD = 3'd2;

	// Replaces the enabled byte lanes of a word
	function automatic data_t lane_merge(data_t old_w, data_t new_w, strb_t sel);
		data_t res;
		res = old_w;
		for (int b = 0; b < $bits(strb_t); b++) begin
			if (sel[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		end
		return res;
	endfunction

endpackage

`default_nettype wire

/* src/processorci_cfg_pkg.sv */
`default_nettype none

package processorci_cfg_pkg;

	// Program/data memory, 4 KiB
	localparam int MEM_WORDS = 1024;
	typedef logic [$clog2(MEM_WORDS)-1:0] mem_index_t;

	localparam logic [31:0] MEM_BASE = 32'h0000_0000;
	localparam logic [31:0] MEM_SPAN = 32'h0000_1000;   // Bytes

	// Machine timer block
	localparam logic [31:0] TIMER_BASE  = 32'h8000_0000;
	localparam logic [31:0] TIMER_SPAN  = 32'h0000_0010;
	localparam logic [3:0]  MTIME_LO    = 4'h0;   // Byte offsets
	localparam logic [3:0]  MTIME_HI    = 4'h4;
	localparam logic [3:0]  MTIMECMP_LO = 4'h8;
	localparam logic [3:0]  MTIMECMP_HI = 4'hC;

	typedef logic [63:0] mtime_t;

	// Core held in reset this many cycles after system reset
	localparam int RESET_CLK_CYCLES = 16;
	typedef logic [$clog2(RESET_CLK_CYCLES+1)-1:0] reset_cnt_t;

endpackage

`default_nettype wire

/* src/processorci_top.sv */
`default_nettype none

module processorci_top
	import processorci_bus_pkg::*;
	import processorci_cfg_pkg::*;
(
	input  logic    sys_clk_i,
	input  logic    rst_i,

	// Core AHB-Lite manager port
	input  addr_t   haddr_i,
	input  logic    hwrite_i,
	input  htrans_t htrans_i,
	input  hsize_t  hsize_i,
	input  data_t   hwdata_i,
	output data_t   hrdata_o,
	output logic    hready_o,
	output logic    hresp_o,

	output logic    rst_core_o,
	output logic    timer_irq_o
);

	logic  wb_cyc;
	logic  wb_stb;
	logic  wb_we;
	addr_t wb_adr;
	strb_t wb_sel;
	data_t wb_wdat;
	data_t wb_rdat;
	logic  wb_ack;
	logic  wb_err;

	// Per target
	logic  mem_stb;
	logic  tmr_stb;
	data_t mem_dat;
	data_t tmr_dat;
	logic  mem_ack;
	logic  tmr_ack;

	core_reset_ctrl u_reset (
		.sys_clk_i  (sys_clk_i),
		.rst_i      (rst_i),
		.rst_core_o (rst_core_o)
	);

	ahb_wb_bridge u_bridge (
		.sys_clk_i (sys_clk_i),
		.rst_i     (rst_i),
		.haddr_i   (haddr_i),
		.hwrite_i  (hwrite_i),
		.htrans_i  (htrans_i),
		.hsize_i   (hsize_i),
		.hwdata_i  (hwdata_i),
		.hrdata_o  (hrdata_o),
		.hready_o  (hready_o),
		.hresp_o   (hresp_o),
		.wb_cyc_o  (wb_cyc),
		.wb_stb_o  (wb_stb),
		.wb_we_o   (wb_we),
		.wb_adr_o  (wb_adr),
		.wb_sel_o  (wb_sel),
		.wb_dat_o  (wb_wdat),
		.wb_dat_i  (wb_rdat),
		.wb_ack_i  (wb_ack),
		.wb_err_i  (wb_err)
	);

	wb_addr_decode u_decode (
		.sys_clk_i (sys_clk_i),
		.rst_i     (rst_i),
		.wb_stb_i  (wb_stb),
		.wb_cyc_i  (wb_cyc),
		.wb_adr_i  (wb_adr),
		.wb_dat_o  (wb_rdat),
		.wb_ack_o  (wb_ack),
		.wb_err_o  (wb_err),
		.mem_stb_o (mem_stb),
		.tmr_stb_o (tmr_stb),
		.mem_dat_i (mem_dat),
		.tmr_dat_i (tmr_dat),
		.mem_ack_i (mem_ack),
		.tmr_ack_i (tmr_ack)
	);

	wb_memory u_mem (
		.sys_clk_i (sys_clk_i),
		.rst_i     (rst_i),
		.stb_i     (mem_stb),
		.we_i      (wb_we),
		.adr_i     (mem_index_t'(wb_adr[2 +: $bits(mem_index_t)])),   // Word index
		.sel_i     (wb_sel),
		.dat_i     (wb_wdat),
		.dat_o     (mem_dat),
		.ack_o     (mem_ack)
	);

	wb_mtimer u_mtimer (
		.sys_clk_i   (sys_clk_i),
		.rst_i       (rst_i),
		.stb_i       (tmr_stb),
		.we_i        (wb_we),
		.adr_i       (wb_adr[3:2]),
		.sel_i       (wb_sel),
		.dat_i       (wb_wdat),
		.dat_o       (tmr_dat),
		.ack_o       (tmr_ack),
		.timer_irq_o (timer_irq_o)
	);

endmodule

`default_nettype wire

/* src/wb_addr_decode.sv */
`default_nettype none

module wb_addr_decode
	import processorci_bus_pkg::*;
	import processorci_cfg_pkg::*;
(
	input  logic  sys_clk_i,
	input  logic  rst_i,
	input  logic  wb_stb_i,
	input  logic  wb_cyc_i,
	input  addr_t wb_adr_i,
	output data_t wb_dat_o,
	output logic  wb_ack_o,
	output logic  wb_err_o,
	output logic  mem_stb_o,
	output logic  tmr_stb_o,
	input  data_t mem_dat_i,
	input  data_t tmr_dat_i,
	input  logic  mem_ack_i,
	input  logic  tmr_ack_i
);

	logic req;
	logic mem_hit;
	logic tmr_hit;
	logic err_q;

	assign req = wb_cyc_i && wb_stb_i;

	// Offset compare, wraps below the base
	assign mem_hit = (wb_adr_i - MEM_BASE) < MEM_SPAN;
	assign tmr_hit = (wb_adr_i - TIMER_BASE) < TIMER_SPAN;

	assign mem_stb_o = req && mem_hit;
	assign tmr_stb_o = req && tmr_hit;

	// Unmapped access gets a single err pulse
	always_ff @(posedge sys_clk_i) begin
		if (rst_i)
			err_q <= 1'b0;
		else
			err_q <= req && !mem_hit && !tmr_hit && !err_q;
	end

	assign wb_err_o = err_q;
	assign wb_ack_o = (mem_hit && mem_ack_i) || (tmr_hit && tmr_ack_i);
	assign wb_dat_o = tmr_hit ? tmr_dat_i : mem_dat_i;

endmodule

`default_nettype wire

/* src/wb_memory.sv */
`default_nettype none

module wb_memory
	import processorci_bus_pkg::*;
	import processorci_cfg_pkg::*;
(
	input  logic       sys_clk_i,
	input  logic       rst_i,
	input  logic       stb_i,
	input  logic       we_i,
	input  mem_index_t adr_i,
	input  strb_t      sel_i,
	input  data_t      dat_i,
	output data_t      dat_o,
	output logic       ack_o
);

	data_t mem_q [MEM_WORDS];
	data_t dat_q;
	logic  ack_q;
	logic  first;   // First cycle of a strobe

	assign first = stb_i && !ack_q;

	// One ack per strobe, back to zero while stb stays high for the next one
	always_ff @(posedge sys_clk_i) begin
		if (rst_i)
			ack_q <= 1'b0;
		else
			ack_q <= first;
	end

	always_ff @(posedge sys_clk_i) begin
		if (first && we_i)
			mem_q[adr_i] <= lane_merge(mem_q[adr_i], dat_i, sel_i);
	end

	// Whole word returned whatever the lanes
	always_ff @(posedge sys_clk_i) begin
		if (first)
			dat_q <= mem_q[adr_i];
	end

	assign dat_o = dat_q;
	assign ack_o = ack_q;

endmodule

`default_nettype wire

/* src/wb_mtimer.sv */
`default_nettype none

module wb_mtimer
	import processorci_bus_pkg::*;
	import processorci_cfg_pkg::*;
(
	input  logic       sys_clk_i,
	input  logic       rst_i,
	input  logic       stb_i,
	input  logic       we_i,
	input  logic [1:0] adr_i,   // Word index within the block
	input  strb_t      sel_i,
	input  data_t      dat_i,
	output data_t      dat_o,
	output logic       ack_o,
	output logic       timer_irq_o
);

	mtime_t mtime_q;
	mtime_t mtimecmp_q;
	data_t  dat_q;
	logic   ack_q;
	logic   irq_q;
	logic   first;
	logic   wr;

	assign first = stb_i && !ack_q;
	assign wr    = first && we_i;

	always_ff @(posedge sys_clk_i) begin
		if (rst_i) begin
			mtime_q    <= '0;
			mtimecmp_q <= '1;   // No interrupt until compare is written
			ack_q      <= 1'b0;
			irq_q      <= 1'b0;
		end else begin
			mtime_q <= mtime_q + 1'b1;
			ack_q   <= first;
			irq_q   <= (mtime_q >= mtimecmp_q);
			if (wr && adr_i == MTIMECMP_LO[3:2])
				mtimecmp_q[31:0] <= lane_merge(mtimecmp_q[31:0], dat_i, sel_i);
			if (wr && adr_i == MTIMECMP_HI[3:2])
				mtimecmp_q[63:32] <= lane_merge(mtimecmp_q[63:32], dat_i, sel_i);
		end
	end

	// Read data sampled with the ack
	always_ff @(posedge sys_clk_i) begin
		if (first) begin
			case (adr_i)
				MTIME_LO[3:2]:    dat_q <= mtime_q[31:0];
				MTIME_HI[3:2]:    dat_q <= mtime_q[63:32];
				MTIMECMP_LO[3:2]: dat_q <= mtimecmp_q[31:0];
				default:          dat_q <= mtimecmp_q[63:32];
			endcase
		end
	end

	assign dat_o       = dat_q;
	assign ack_o       = ack_q;
	assign timer_irq_o = irq_q;

endmodule

`default_nettype wire
